//--- project.f
+incdir+hdl
hdl/m6502_pkg.sv
hdl/m6502_alu.sv
hdl/m6502_addr_gen.sv
hdl/m6502_control.sv
hdl/m6502_top.sv
test/tb_clock_gen.sv
test/tb_m6502.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_m6502 -f project.f \
  -o sim_m6502 > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }

./obj_dir/sim_m6502 > sim.log 2>&1
cat sim.log
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1
exit 0

//--- test/tb_m6502.sv
//----------------------------------------
// Testbench for the 6502 subset core.
// Builds a test program in a 64 KiB memory
// model, predicts every store with its own
// model and checks the bus by assertions.
// A second reset run hits an illegal group.
//----------------------------------------
`timescale 1ns/10ps
`include "m6502_defines.svh"

module tb_m6502
  import m6502_pkg::*;
();

  logic        raw_clk;
  logic        button_reset;
  logic        restart;
  addr_t       mem_address;
  byte_t       mem_wdata;
  logic        mem_write;
  byte_t       mem_rdata;
  logic        cpu_halted;
  logic        cpu_error;

  byte_t       mem [0:65535];
  addr_t       bus_addr;
  byte_t       bus_data;
  logic        bus_wr;

  // Program builder and reference model state
  addr_t       pc_b;
  logic        carry;
  logic [31:0] lfsr;
  int          n_instr;
  int          cycles;
  int          limit;
  string       test_name;
  logic [23:0] exp_q [$];
  string       name_q [$];
  logic [23:0] exp_head;
  string       head_name;
  int          pending;
  logic        err_run;
  int          data_errs;
  int          other_errs;

  // Opcodes indexed by register A, X or Y
  localparam byte_t ld_imm_op [0:2] = '{8'hA9, 8'hA2, 8'hA0};
  localparam byte_t ld_zp_op  [0:2] = '{8'hA5, 8'hA6, 8'hA4};
  localparam byte_t ld_abs_op [0:2] = '{8'hAD, 8'hAE, 8'hAC};
  localparam byte_t st_zp_op  [0:2] = '{8'h85, 8'h86, 8'h84};
  localparam byte_t st_abs_op [0:2] = '{8'h8D, 8'h8E, 8'h8C};
  // Immediate ORA AND EOR ADC SBC CMP
  localparam byte_t alu_opcode [0:5] = '{8'h09, 8'h29, 8'h49, 8'h69, 8'hE9, 8'hC9};
  // ASL ROL LSR ROR on A
  localparam byte_t shift_op [0:3] = '{8'h0A, 8'h2A, 8'h4A, 8'h6A};

  tb_clock_gen u_clock_gen (
    .restart      (restart),
    .raw_clk      (raw_clk),
    .button_reset (button_reset)
  );

  m6502_top u_dut (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .mem_address  (mem_address),
    .mem_wdata    (mem_wdata),
    .mem_write    (mem_write),
    .mem_rdata    (mem_rdata),
    .cpu_halted   (cpu_halted),
    .cpu_error    (cpu_error)
  );

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
  function automatic byte_t rand_bits(input int n);
    byte_t v;
    v = 8'h00;
    for (int i = 0; i < n; i++)
    begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[6:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic byte_t fill_byte(input addr_t a);
    return a[7:0] ^ {a[11:8], a[15:12]} ^ 8'hA5;
  endfunction

  function automatic void refresh_head();
    pending = exp_q.size();
    if (pending != 0)
    begin
      exp_head = exp_q[0];
      head_name = name_q[0];
    end
  endfunction

  task automatic emit(input byte_t b);
    mem[pc_b] = b;
    pc_b = pc_b + 16'd1;
  endtask

  task automatic op1(input byte_t op);
    emit(op);
    n_instr++;
  endtask

  task automatic op2(input byte_t op, input byte_t arg);
    op1(op);
    emit(arg);
  endtask

  task automatic op3(input byte_t op, input addr_t arg);
    op1(op);
    emit(arg[7:0]);
    emit(arg[15:8]);
  endtask

  task automatic expect_write(input addr_t a, input byte_t d);
    exp_q.push_back({a, d});
    name_q.push_back(test_name);
  endtask

  task automatic set_carry();
    byte_t r;
    r = rand_bits(1);
    carry = r[0];
    // SEC or CLC
    op1(carry ? 8'h38 : 8'h18);
  endtask

  // LDA #0 then ADC #0 turns C into a stored byte
  task automatic check_carry(input byte_t zp);
    op2(8'hA9, 8'h00);
    op2(8'h69, 8'h00);
    op2(8'h85, zp);
    expect_write({8'h00, zp}, {7'h00, carry});
    carry = 1'b0;
  endtask

  task automatic load_store_reg(input logic [1:0] r);
    byte_t v;
    byte_t lo;
    addr_t src;
    v = rand_bits(8);
    op2(ld_imm_op[r], v);
    op2(st_zp_op[r], 8'h80 | {6'h00, r});
    expect_write({8'h00, 8'h80 | {6'h00, r}}, v);
    // Zero page source in 0010..001F
    v = rand_bits(4);
    src = {8'h00, 4'h1, v[3:0]};
    op2(ld_zp_op[r], src[7:0]);
    op3(st_abs_op[r], 16'h0400 | {14'h0000, r});
    expect_write(16'h0400 | {14'h0000, r}, mem[src]);
    // Absolute source in 1000..1FFF
    lo = rand_bits(8);
    v = rand_bits(8);
    src = {4'h1, v[3:0], lo};
    op3(ld_abs_op[r], src);
    op2(st_zp_op[r], 8'h90 | {6'h00, r});
    expect_write({8'h00, 8'h90 | {6'h00, r}}, mem[src]);
  endtask

  task automatic alu_imm(input logic [2:0] k);
    byte_t a;
    byte_t b;
    byte_t res;
    logic [8:0] sum;
    set_carry();
    a = rand_bits(8);
    b = rand_bits(8);
    op2(8'hA9, a);
    op2(alu_opcode[k], b);
    case (k)
      3'd0: res = a | b;
      3'd1: res = a & b;
      3'd2: res = a ^ b;
      3'd3:
      begin
        sum = {1'b0, a} + {1'b0, b} + {8'h00, carry};
        res = sum[7:0];
        carry = sum[8];
      end
      3'd4:
      begin
        // Borrow is the inverted carry
        sum = {1'b0, a} - {1'b0, b} - {8'h00, ~carry};
        res = sum[7:0];
        carry = ~sum[8];
      end
      default:
      begin
        res = a;
        carry = (a >= b);
      end
    endcase
    op2(8'h85, 8'hA0 | {5'h00, k});
    expect_write({8'h00, 8'hA0 | {5'h00, k}}, res);
    if (k >= 3'd3)
      check_carry(8'hB0 | {5'h00, k});
  endtask

  task automatic indexed_stores();
    byte_t xi;
    byte_t yi;
    byte_t v;
    byte_t zb;
    byte_t zx;
    // X of 40 or more from a base of C0 always wraps
    xi = rand_bits(8) | 8'h40;
    yi = rand_bits(8);
    v = rand_bits(8);
    zb = 8'hC0 | rand_bits(6);
    zx = zb + xi;
    op2(8'hA2, xi);
    op2(8'hA0, yi);
    op2(8'hA9, v);
    op3(8'h9D, 16'h0500);
    expect_write(16'h0500 + {8'h00, xi}, v);
    op3(8'h99, 16'h05F0);
    expect_write(16'h05F0 + {8'h00, yi}, v);
    op2(8'h95, zb);
    expect_write({8'h00, zx}, v);
  endtask

  task automatic transfers();
    byte_t v;
    v = rand_bits(8);
    op2(8'hA9, v);
    op1(8'hAA);
    op1(8'hA8);
    op1(8'hE8);
    op1(8'h88);
    op2(8'h86, 8'hD0);
    expect_write(16'h00D0, v + 8'd1);
    op2(8'h84, 8'hD1);
    expect_write(16'h00D1, v - 8'd1);
    op1(8'h8A);
    op2(8'h85, 8'hD2);
    expect_write(16'h00D2, v + 8'd1);
    op1(8'h98);
    op2(8'h85, 8'hD3);
    expect_write(16'h00D3, v - 8'd1);
    // Wrap at both ends
    op2(8'hA2, 8'hFF);
    op1(8'hE8);
    op2(8'h86, 8'hD4);
    expect_write(16'h00D4, 8'h00);
    op2(8'hA0, 8'h00);
    op1(8'h88);
    op2(8'h84, 8'hD5);
    expect_write(16'h00D5, 8'hFF);
  endtask

  task automatic shift_acc(input logic [1:0] s);
    byte_t v;
    byte_t res;
    set_carry();
    v = rand_bits(8);
    op2(8'hA9, v);
    op1(shift_op[s]);
    case (s)
      2'd0:
      begin
        res = {v[6:0], 1'b0};
        carry = v[7];
      end
      2'd1:
      begin
        res = {v[6:0], carry};
        carry = v[7];
      end
      2'd2:
      begin
        res = {1'b0, v[7:1]};
        carry = v[0];
      end
      default:
      begin
        res = {carry, v[7:1]};
        carry = v[0];
      end
    endcase
    op2(8'h85, 8'hE0 | {6'h00, s});
    expect_write({8'h00, 8'hE0 | {6'h00, s}}, res);
    check_carry(8'hE8 | {6'h00, s});
  endtask

  // STX abs, DEX, BNE back by 6 bytes
  task automatic dex_loop();
    byte_t n;
    n = rand_bits(3) + 8'd1;
    op2(8'hA2, n);
    for (int i = int'(n); i > 0; i--)
      expect_write(16'h0700, i[7:0]);
    op3(8'h8E, 16'h0700);
    op1(8'hCA);
    op2(8'hD0, 8'hFA);
    n_instr = n_instr + 3 * (int'(n) - 1);
  endtask

  task automatic jump_skip();
    byte_t v;
    v = rand_bits(8);
    op3(8'h4C, pc_b + 16'd5);
    // Any write from this skipped store is unexpected
    op2(8'h85, 8'hEE);
    op2(8'hA9, v);
    op2(8'h85, 8'hEF);
    expect_write(16'h00EF, v);
  endtask

  // Bus sampled mid-cycle and answered just after the next rising edge
  always @(negedge raw_clk)
  begin
    bus_addr = mem_address;
    bus_data = mem_wdata;
    bus_wr = mem_write;
  end

  always @(posedge raw_clk)
  begin
    #1;
    mem_rdata = mem[bus_addr];
    if (bus_wr)
    begin
      mem[bus_addr] = bus_data;
      if (exp_q.size() > 0)
      begin
        void'(exp_q.pop_front());
        void'(name_q.pop_front());
      end
      refresh_head();
    end
  end

  always @(posedge raw_clk)
  begin
    cycles++;
    if (cycles > limit)
    begin
      $display("timeout after %0d cycles with %0d stores outstanding", cycles, pending);
      $display("errors: data %0d, other %0d, stores left %0d", data_errs, other_errs, pending);
      $display("sim failed");
      $finish;
    end
  end

  write_expected: assert property (@(negedge raw_clk) disable iff (!button_reset)
    mem_write |-> pending != 0)
    else
    begin
      other_errs++;
      $display("unexpected write of %h to %h", mem_wdata, mem_address);
    end

  write_matches: assert property (@(negedge raw_clk) disable iff (!button_reset)
    (mem_write && pending != 0) |-> {mem_address, mem_wdata} == exp_head)
    else
    begin
      data_errs++;
      $display("ERR %s: expected %h at %h, actual %h at %h", head_name,
               exp_head[7:0], exp_head[23:8], mem_wdata, mem_address);
    end

  halt_clean: assert property (@(negedge raw_clk) disable iff (!button_reset)
    cpu_halted |-> pending == 0 && !mem_write)
    else
    begin
      other_errs++;
      $display("halted with %0d stores still expected, or wrote after halt", pending);
    end

  error_only_in_test: assert property (@(negedge raw_clk) disable iff (!button_reset)
    cpu_error |-> err_run && !mem_write)
    else
    begin
      other_errs++;
      $display("error stop outside the illegal-opcode run, or write after it");
    end

  initial
  begin
    byte_t v;
    mem_rdata = 8'h00;
    restart = 1'b0;
    bus_wr = 1'b0;
    bus_addr = 16'h0000;
    bus_data = 8'h00;
    err_run = 1'b0;
    data_errs = 0;
    other_errs = 0;
    cycles = 0;
    n_instr = 0;
    carry = 1'b0;
    lfsr = 32'h4ebb;
    for (int i = 0; i < 65536; i++)
      mem[i[15:0]] = fill_byte(i[15:0]);
    pc_b = `M6502_RESET_PC;
    test_name = "load_store";
    for (int r = 0; r < 3; r++)
      load_store_reg(r[1:0]);
    test_name = "alu_ops";
    for (int k = 0; k < 6; k++)
      alu_imm(k[2:0]);
    test_name = "indexed";
    indexed_stores();
    test_name = "reg_ops";
    transfers();
    test_name = "shifts";
    for (int s = 0; s < 4; s++)
      shift_acc(s[1:0]);
    test_name = "loop";
    dex_loop();
    test_name = "jmp";
    jump_skip();
    op1(8'h00);
    // One more for the illegal opcode of the second run
    n_instr++;
    limit = n_instr * 12 + 100;
    refresh_head();

    wait (cpu_halted || cpu_error);
    repeat (4) @(posedge raw_clk);

    // Second run with a cc = 11 opcode at the reset address
    test_name = "illegal";
    v = rand_bits(8);
    mem[`M6502_RESET_PC] = {v[7:2], 2'b11};
    err_run = 1'b1;
    @(posedge raw_clk);
    #1 restart = 1'b1;
    @(posedge raw_clk);
    #1 restart = 1'b0;
    wait (cpu_error);
    repeat (4) @(posedge raw_clk);

    $display("errors: data %0d, other %0d, stores left %0d", data_errs, other_errs, pending);
    if (data_errs == 0 && other_errs == 0 && pending == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

//--- test/tb_clock_gen.sv
//----------------------------------------
// Clock and reset source for the 6502
// testbench. 8 ns raw_clk; button_reset is
// held low for 8 cycles at start and again
// after each pulse on restart.
//----------------------------------------
`timescale 1ns/10ps

module tb_clock_gen (
  input  logic restart,
  output logic raw_clk,
  output logic button_reset
);

  initial
  begin
    raw_clk = 1'b0;
    forever #4 raw_clk = ~raw_clk;
  end

  // Reset edges land just after a rising clock edge
  initial
  begin
    button_reset = 1'b0;
    forever
    begin
      repeat (8) @(posedge raw_clk);
      #1 button_reset = 1'b1;
      @(posedge restart);
      #1 button_reset = 1'b0;
    end
  end

endmodule

//--- hdl/m6502_top.sv
//----------------------------------------
// Top level of the 6502 subset core.
// Connects control, ALU and address
// generator; the byte-wide memory bus and
// the stop flags are the only ports.
//----------------------------------------
`timescale 1ns/10ps

module m6502_top
  import m6502_pkg::*;
(
  input  logic  raw_clk,
  input  logic  button_reset,
  output addr_t mem_address,
  output byte_t mem_wdata,
  output logic  mem_write,
  input  byte_t mem_rdata,
  output logic  cpu_halted,
  output logic  cpu_error
);

  alu_op_e    alu_op;
  byte_t      alu_a;
  byte_t      alu_b;
  logic       carry_in;
  byte_t      alu_result;
  flags_t     alu_flags;
  addr_mode_e addr_mode;
  byte_t      operand_lo;
  byte_t      operand_hi;
  byte_t      index_x;
  byte_t      index_y;
  addr_t      pc;
  addr_t      eff_address;
  addr_t      branch_target;

  m6502_control u_control (
    .raw_clk       (raw_clk),
    .button_reset  (button_reset),
    .mem_address   (mem_address),
    .mem_wdata     (mem_wdata),
    .mem_write     (mem_write),
    .mem_rdata     (mem_rdata),
    .alu_op        (alu_op),
    .alu_a         (alu_a),
    .alu_b         (alu_b),
    .carry_in      (carry_in),
    .alu_result    (alu_result),
    .alu_flags     (alu_flags),
    .addr_mode     (addr_mode),
    .operand_lo    (operand_lo),
    .operand_hi    (operand_hi),
    .index_x       (index_x),
    .index_y       (index_y),
    .pc            (pc),
    .eff_address   (eff_address),
    .branch_target (branch_target),
    .cpu_halted    (cpu_halted),
    .cpu_error     (cpu_error)
  );

  m6502_alu u_alu (
    .alu_op     (alu_op),
    .alu_a      (alu_a),
    .alu_b      (alu_b),
    .carry_in   (carry_in),
    .alu_result (alu_result),
    .alu_flags  (alu_flags)
  );

  // Address and branch target settle in the same cycle as the ALU
  m6502_addr_gen u_addr_gen (
    .addr_mode     (addr_mode),
    .operand_lo    (operand_lo),
    .operand_hi    (operand_hi),
    .index_x       (index_x),
    .index_y       (index_y),
    .pc            (pc),
    .eff_address   (eff_address),
    .branch_target (branch_target)
  );

endmodule

//--- hdl/m6502_control.sv
//----------------------------------------
// Fetch, decode and execute FSM of the
// 6502 subset core. Holds PC, A, X, Y and
// the status byte, drives the memory bus
// and steers the ALU and address generator.
//----------------------------------------
`timescale 1ns/10ps
`include "m6502_defines.svh"

module m6502_control
  import m6502_pkg::*;
(
  input  logic       raw_clk,
  input  logic       button_reset,
  output addr_t      mem_address,
  output byte_t      mem_wdata,
  output logic       mem_write,
  input  byte_t      mem_rdata,
  output alu_op_e    alu_op,
  output byte_t      alu_a,
  output byte_t      alu_b,
  output logic       carry_in,
  input  byte_t      alu_result,
  input  flags_t     alu_flags,
  output addr_mode_e addr_mode,
  output byte_t      operand_lo,
  output byte_t      operand_hi,
  output byte_t      index_x,
  output byte_t      index_y,
  output addr_t      pc,
  input  addr_t      eff_address,
  input  addr_t      branch_target,
  output logic       cpu_halted,
  output logic       cpu_error
);

  cpu_state_e state;
  cpu_state_e operand_next;
  byte_t      reg_a;
  byte_t      reg_x;
  byte_t      reg_y;
  flags_t     status;
  byte_t      opcode;
  byte_t      data_reg;
  logic [2:0] op_aaa;
  logic [2:0] op_bbb;
  logic [1:0] op_cc;
  logic       ldst_x;
  logic [1:0] n_bytes;
  logic       legal;
  logic       needs_read;
  logic       is_store;
  logic       is_brk;
  logic       is_jmp;
  logic       is_bne;
  logic       is_carry_op;
  logic       wr_a;
  logic       wr_x;
  logic       wr_y;
  logic       wr_flags;

  assign op_aaa = opcode[`M6502_OP_MSB:`M6502_OP_LSB];
  assign op_bbb = opcode[`M6502_MODE_MSB:`M6502_MODE_LSB];
  assign op_cc  = opcode[`M6502_GROUP_MSB:0];
  // LDX/STX live in group 10, LDY/STY in group 00
  assign ldst_x = op_cc[1];

  // Instruction decode, stable for the whole instruction
  always_comb
  begin
    addr_mode = AM_ZP;
    n_bytes = 2'd0;
    legal = 1'b1;
    needs_read = 1'b0;
    is_store = 1'b0;
    is_brk = 1'b0;
    is_jmp = 1'b0;
    is_bne = 1'b0;
    is_carry_op = 1'b0;
    wr_a = 1'b0;
    wr_x = 1'b0;
    wr_y = 1'b0;
    wr_flags = 1'b0;
    alu_op = ALU_PASS;
    alu_a = reg_a;
    alu_b = data_reg;
    mem_wdata = reg_a;
    if (op_cc == 2'b01)
    begin
      // Accumulator group; the indirect modes are not supported
      case (op_bbb)
        3'b001:  addr_mode = AM_ZP;
        3'b010:  addr_mode = AM_ZP;
        3'b011:  addr_mode = AM_ABS;
        3'b101:  addr_mode = AM_ZP_X;
        3'b110:  addr_mode = AM_ABS_Y;
        3'b111:  addr_mode = AM_ABS_X;
        default: legal = 1'b0;
      endcase
      n_bytes = (op_bbb[1] && (op_bbb[0] || op_bbb[2])) ? 2'd2 : 2'd1;
      case (op_aaa)
        3'b000:  alu_op = ALU_OR;
        3'b001:  alu_op = ALU_AND;
        3'b010:  alu_op = ALU_EOR;
        3'b011:  alu_op = ALU_ADC;
        3'b110:  alu_op = ALU_CMP;
        3'b111:  alu_op = ALU_SBC;
        default: alu_op = ALU_PASS;
      endcase
      if (op_aaa == 3'b100)
      begin
        is_store = 1'b1;
        if (op_bbb == 3'b010)
          legal = 1'b0;
      end
      else
      begin
        needs_read = (op_bbb != 3'b010);
        wr_flags = 1'b1;
        // CMP only touches flags
        wr_a = (op_aaa != 3'b110);
      end
    end
    else if (op_cc != 2'b11 && op_aaa[2:1] == 2'b10 && (op_bbb == 3'b000 || op_bbb[0]))
    begin
      // LDX, LDY, STX, STY
      n_bytes = op_bbb[1] ? 2'd2 : 2'd1;
      case (op_bbb)
        3'b000:  addr_mode = AM_ZP;
        3'b001:  addr_mode = AM_ZP;
        3'b011:  addr_mode = AM_ABS;
        3'b101:  addr_mode = AM_ZP_X;
        default: addr_mode = ldst_x ? AM_ABS_Y : AM_ABS_X;
      endcase
      // No zero page Y in this core
      if (ldst_x && op_bbb == 3'b101)
        legal = 1'b0;
      if (op_aaa[0])
      begin
        needs_read = (op_bbb != 3'b000);
        wr_flags = 1'b1;
        wr_x = ldst_x;
        wr_y = !ldst_x;
      end
      else
      begin
        is_store = 1'b1;
        mem_wdata = ldst_x ? reg_x : reg_y;
        if (op_bbb == 3'b000 || op_bbb == 3'b111)
          legal = 1'b0;
      end
    end
    else
    begin
      // Single-byte and control-flow opcodes
      case (opcode)
        8'h00: is_brk = 1'b1;
        8'h18, 8'h38: is_carry_op = 1'b1;
        8'h4C:
        begin
          addr_mode = AM_ABS;
          n_bytes = 2'd2;
          is_jmp = 1'b1;
        end
        8'hD0:
        begin
          addr_mode = AM_REL;
          n_bytes = 2'd1;
          is_bne = 1'b1;
        end
        8'hE8, 8'hCA:
        begin
          alu_a = reg_x;
          alu_op = (opcode == 8'hE8) ? ALU_INC : ALU_DEC;
          wr_x = 1'b1;
          wr_flags = 1'b1;
        end
        8'hC8, 8'h88:
        begin
          alu_a = reg_y;
          alu_op = (opcode == 8'hC8) ? ALU_INC : ALU_DEC;
          wr_y = 1'b1;
          wr_flags = 1'b1;
        end
        8'hAA, 8'hA8:
        begin
          alu_b = reg_a;
          wr_x = (opcode == 8'hAA);
          wr_y = (opcode == 8'hA8);
          wr_flags = 1'b1;
        end
        8'h8A, 8'h98:
        begin
          alu_b = (opcode == 8'h8A) ? reg_x : reg_y;
          wr_a = 1'b1;
          wr_flags = 1'b1;
        end
        8'h0A, 8'h2A, 8'h4A, 8'h6A:
        begin
          case (opcode[6:5])
            2'b00:   alu_op = ALU_ASL;
            2'b01:   alu_op = ALU_ROL;
            2'b10:   alu_op = ALU_LSR;
            default: alu_op = ALU_ROR;
          endcase
          wr_a = 1'b1;
          wr_flags = 1'b1;
        end
        // cc = 11 and every unsupported opcode stop here
        default: legal = 1'b0;
      endcase
    end
  end

  // Where to go once all operand bytes are in
  assign operand_next = needs_read ? ST_READ_0 : (is_store ? ST_STORE : ST_EXECUTE);

  assign carry_in = status[`M6502_FLAG_C];
  assign index_x = reg_x;
  assign index_y = reg_y;
  assign mem_address = (state == ST_READ_0 || state == ST_STORE) ? eff_address : pc;
  assign mem_write = (state == ST_STORE);
  assign cpu_halted = (state == ST_HALTED);
  assign cpu_error = (state == ST_ERROR);

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      state <= ST_RESET;
      pc <= `M6502_RESET_PC;
      reg_a <= '0;
      reg_x <= '0;
      reg_y <= '0;
      status <= '0;
    end
    else
    begin
      case (state)
        ST_RESET:      state <= ST_FETCH_OP_0;
        ST_FETCH_OP_0: state <= ST_FETCH_OP_1;
        ST_FETCH_OP_1:
        begin
          opcode <= mem_rdata;
          pc <= pc + 16'd1;
          state <= ST_DECODE;
        end
        ST_DECODE:
          if (!legal)
            state <= ST_ERROR;
          else if (is_brk)
            state <= ST_HALTED;
          else if (n_bytes != 2'd0)
            state <= ST_FETCH_LO_0;
          else
            state <= ST_EXECUTE;
        ST_FETCH_LO_0: state <= ST_FETCH_LO_1;
        ST_FETCH_LO_1:
        begin
          // Immediate operands go straight to the data register
          operand_lo <= mem_rdata;
          data_reg <= mem_rdata;
          pc <= pc + 16'd1;
          state <= (n_bytes == 2'd2) ? ST_FETCH_HI_0 : operand_next;
        end
        ST_FETCH_HI_0: state <= ST_FETCH_HI_1;
        ST_FETCH_HI_1:
        begin
          operand_hi <= mem_rdata;
          pc <= pc + 16'd1;
          state <= operand_next;
        end
        ST_READ_0:     state <= ST_READ_1;
        ST_READ_1:
        begin
          data_reg <= mem_rdata;
          state <= ST_EXECUTE;
        end
        ST_EXECUTE:
        begin
          if (wr_a)
            reg_a <= alu_result;
          if (wr_x)
            reg_x <= alu_result;
          if (wr_y)
            reg_y <= alu_result;
          if (wr_flags)
          begin
            status[`M6502_FLAG_N] <= alu_flags[`M6502_FLAG_N];
            status[`M6502_FLAG_Z] <= alu_flags[`M6502_FLAG_Z];
            status[`M6502_FLAG_C] <= alu_flags[`M6502_FLAG_C];
            if (alu_op == ALU_ADC || alu_op == ALU_SBC)
              status[`M6502_FLAG_V] <= alu_flags[`M6502_FLAG_V];
          end
          // CLC is 18, SEC is 38
          if (is_carry_op)
            status[`M6502_FLAG_C] <= op_aaa[0];
          if (is_jmp)
            pc <= eff_address;
          else if (is_bne && !status[`M6502_FLAG_Z])
            pc <= branch_target;
          state <= ST_FETCH_OP_0;
        end
        ST_STORE:      state <= ST_FETCH_OP_0;
        ST_HALTED:     state <= ST_HALTED;
        ST_ERROR:      state <= ST_ERROR;
        default:       state <= ST_ERROR;
      endcase
    end
  end

  // A stopped core stays stopped and never writes again
  assert property (@(posedge raw_clk) disable iff (!button_reset)
    (cpu_halted || cpu_error) |=> $stable({cpu_halted, cpu_error}) && !mem_write)
    else $error("control: bus write or exit after stop");

  // Stores are single-cycle pulses
  assert property (@(posedge raw_clk) disable iff (!button_reset)
    mem_write |=> !mem_write)
    else $error("control: mem_write high for two cycles");

endmodule

//--- hdl/m6502_addr_gen.sv
//----------------------------------------
// Effective address and branch target
// generator. Purely combinational; fed by
// the control FSM with operand bytes,
// index registers and the current PC.
//----------------------------------------
`timescale 1ns/10ps

module m6502_addr_gen
  import m6502_pkg::*;
(
  input  addr_mode_e addr_mode,
  input  byte_t      operand_lo,
  input  byte_t      operand_hi,
  input  byte_t      index_x,
  input  byte_t      index_y,
  input  addr_t      pc,
  output addr_t      eff_address,
  output addr_t      branch_target
);

  addr_t abs_base;
  byte_t zp_x;

  assign abs_base = {operand_hi, operand_lo};

  // 8-bit sum, so zero page X never leaves page zero
  assign zp_x = operand_lo + index_x;

  // PC already points past the offset byte
  assign branch_target = pc + {{8{operand_lo[7]}}, operand_lo};

  always_comb
  begin
    case (addr_mode)
      AM_ZP:    eff_address = {8'h00, operand_lo};
      AM_ZP_X:  eff_address = {8'h00, zp_x};
      AM_ABS:   eff_address = abs_base;
      AM_ABS_X: eff_address = abs_base + {8'h00, index_x};
      AM_ABS_Y: eff_address = abs_base + {8'h00, index_y};
      AM_REL:   eff_address = branch_target;
      default:  eff_address = abs_base;
    endcase
  end

endmodule

//--- hdl/m6502_alu.sv
//----------------------------------------
// Combinational ALU of the 6502 core.
// Control selects the operation and the
// operands; result and flags come back in
// the same cycle.
//----------------------------------------
`timescale 1ns/10ps
`include "m6502_defines.svh"

module m6502_alu
  import m6502_pkg::*;
(
  input  alu_op_e alu_op,
  input  byte_t   alu_a,
  input  byte_t   alu_b,
  input  logic    carry_in,
  output byte_t   alu_result,
  output flags_t  alu_flags
);

  byte_t      b_in;
  logic       sum_cin;
  logic [8:0] sum;
  logic       overflow;
  logic       carry_out;

  // ADC, SBC and CMP share one adder
  always_comb
  begin
    b_in = alu_b;
    sum_cin = carry_in;
    if (alu_op == ALU_SBC || alu_op == ALU_CMP)
      b_in = ~alu_b;
    // Compare ignores the borrow
    if (alu_op == ALU_CMP)
      sum_cin = 1'b1;
    sum = {1'b0, alu_a} + {1'b0, b_in} + {8'h00, sum_cin};
  end

  // Signed overflow when both inputs agree in sign and the sum does not
  assign overflow = (alu_a[7] == b_in[7]) && (sum[7] != alu_a[7]);

  always_comb
  begin
    alu_result = alu_a;
    carry_out = carry_in;
    case (alu_op)
      ALU_OR:   alu_result = alu_a | alu_b;
      ALU_AND:  alu_result = alu_a & alu_b;
      ALU_EOR:  alu_result = alu_a ^ alu_b;
      ALU_ADC, ALU_SBC, ALU_CMP:
      begin
        alu_result = sum[7:0];
        carry_out = sum[8];
      end
      ALU_PASS: alu_result = alu_b;
      ALU_INC:  alu_result = alu_a + 8'd1;
      ALU_DEC:  alu_result = alu_a - 8'd1;
      ALU_ASL:
      begin
        alu_result = {alu_a[6:0], 1'b0};
        carry_out = alu_a[7];
      end
      ALU_LSR:
      begin
        alu_result = {1'b0, alu_a[7:1]};
        carry_out = alu_a[0];
      end
      ALU_ROL:
      begin
        alu_result = {alu_a[6:0], carry_in};
        carry_out = alu_a[7];
      end
      ALU_ROR:
      begin
        alu_result = {carry_in, alu_a[7:1]};
        carry_out = alu_a[0];
      end
      default:  alu_result = alu_a;
    endcase
    alu_flags = '0;
    alu_flags[`M6502_FLAG_N] = alu_result[7];
    alu_flags[`M6502_FLAG_Z] = ~|alu_result;
    alu_flags[`M6502_FLAG_C] = carry_out;
    alu_flags[`M6502_FLAG_V] = overflow && (alu_op == ALU_ADC || alu_op == ALU_SBC);
  end

endmodule

//--- hdl/m6502_pkg.sv
//----------------------------------------
// Shared types of the 6502 subset core.
// Imported by the ALU, the address
// generator, the control FSM and the top.
//----------------------------------------
package m6502_pkg;

  // One data byte or register value
  typedef logic [7:0]  byte_t;
  // Memory address or program counter
  typedef logic [15:0] addr_t;
  // Status byte, N V Z C at their 6502 positions
  typedef logic [7:0]  flags_t;

  typedef enum logic [3:0] {
    ALU_OR,
    ALU_AND,
    ALU_EOR,
    ALU_ADC,
    ALU_SBC,
    ALU_CMP,
    ALU_PASS,
    ALU_INC,
    ALU_DEC,
    ALU_ASL,
    ALU_LSR,
    ALU_ROL,
    ALU_ROR
  } alu_op_e;

  typedef enum logic [2:0] {
    AM_ZP,
    AM_ZP_X,
    AM_ABS,
    AM_ABS_X,
    AM_ABS_Y,
    AM_REL
  } addr_mode_e;

  // Each _0/_1 pair is address cycle then data cycle
  typedef enum logic [3:0] {
    ST_RESET,
    ST_FETCH_OP_0,
    ST_FETCH_OP_1,
    ST_DECODE,
    ST_FETCH_LO_0,
    ST_FETCH_LO_1,
    ST_FETCH_HI_0,
    ST_FETCH_HI_1,
    ST_READ_0,
    ST_READ_1,
    ST_EXECUTE,
    ST_STORE,
    ST_HALTED,
    ST_ERROR
  } cpu_state_e;

endpackage

//--- hdl/m6502_defines.svh
//----------------------------------------
// Fixed constants of the 6502 subset core.
// Include in any file that needs the reset
// vector, status bit positions or opcode
// field positions.
//----------------------------------------
`ifndef M6502_DEFINES_SVH
`define M6502_DEFINES_SVH

// First opcode address after reset
`define M6502_RESET_PC  16'h0200

// Status register bit positions
`define M6502_FLAG_N    7
`define M6502_FLAG_V    6
`define M6502_FLAG_Z    1
`define M6502_FLAG_C    0

// Opcode layout aaabbbcc
`define M6502_OP_MSB    7
`define M6502_OP_LSB    5
`define M6502_MODE_MSB  4
`define M6502_MODE_LSB  2
`define M6502_GROUP_MSB 1

`endif
